// File: hdl/modarith_pkg.sv
`default_nettype none

package modarith_pkg;

    // operand, modulus and result width
    localparam int DATA_W = 256;

    // serial multiplier bit index, counts 0 to DATA_W-1
    localparam int CNT_W = 8;

    // encoding 2'b11 is left unused and decodes as illegal
    typedef enum logic [1:0] {
        OP_ADD = 2'b00, // (a + b) mod m
        OP_SUB = 2'b01, // (a - b) mod m
        OP_MUL = 2'b10  // (a * b) mod m
    } mod_op_e;

    // one command as presented with start
    typedef struct packed {
        mod_op_e           op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] m; // modulus, above 1
    } mod_cmd_t;

    // returned result
    typedef struct packed {
        logic [DATA_W-1:0] value;
        logic              err; // illegal opcode
    } mod_res_t;

endpackage

`default_nettype wire

// File: hdl/modarith_decode.sv
`timescale 1ns/1ps
`default_nettype none

module modarith_decode import modarith_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  mod_cmd_t cmd,
    input  logic     done,
    output mod_cmd_t exe_cmd,
    output logic     add_go,
    output logic     mul_go,
    output logic     bad_op,
    output logic     busy
);

    logic accept;
    logic pend; // command latched, not yet dispatched

    // a start in the done cycle is taken, busy simply stays up
    assign accept = start & (~busy | done);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            pend <= 1'b0;
        end else begin
            pend <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // held constant for the whole command, the multiplier relies on it
    always_ff @(posedge clk) begin
        if (accept) begin
            exe_cmd <= cmd;
        end
    end

    // exactly one pulse per accepted command
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            add_go <= 1'b0;
            mul_go <= 1'b0;
            bad_op <= 1'b0;
        end else begin
            add_go <= 1'b0;
            mul_go <= 1'b0;
            bad_op <= 1'b0;
            if (pend) begin
                case (exe_cmd.op)
                    OP_ADD, OP_SUB: add_go <= 1'b1;
                    OP_MUL:         mul_go <= 1'b1;
                    default:        bad_op <= 1'b1;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/modmul_serial.sv
`timescale 1ns/1ps
`default_nettype none

module modmul_serial import modarith_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              go,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    input  logic [DATA_W-1:0] m,
    output logic [DATA_W-1:0] p,
    output logic              fin
);

    // two guard bits cover s + u and 2u before correction
    localparam int ACC_W = DATA_W + 2;

    logic [ACC_W-1:0] s;       // accumulator
    logic [ACC_W-1:0] u;       // a * 2^cnt mod m
    logic [CNT_W-1:0] cnt;
    logic             run;

    logic             step;
    logic             last;
    logic [CNT_W-1:0] cnt_cur;
    logic [ACC_W-1:0] s_cur;
    logic [ACC_W-1:0] u_cur;
    logic [ACC_W-1:0] m_ext;
    logic [ACC_W-1:0] plus_u;
    logic [ACC_W-1:0] minus_m;
    logic [ACC_W-1:0] new_s;
    logic [ACC_W-1:0] two_u;
    logic [ACC_W-1:0] two_u_m;
    logic [ACC_W-1:0] new_u;

    // bit 0 is processed on the go edge itself
    assign step    = go | run;
    assign cnt_cur = go ? '0 : cnt;
    assign s_cur   = go ? '0 : s;
    assign u_cur   = go ? {2'b00, a} : u;
    assign last    = (cnt_cur == CNT_W'(DATA_W - 1));

    assign m_ext   = {2'b00, m};
    assign plus_u  = s_cur + u_cur;
    assign minus_m = plus_u - m_ext;
    assign new_s   = b[cnt_cur] ? (minus_m[ACC_W-1] ? plus_u : minus_m) : s_cur;

    assign two_u   = {u_cur[ACC_W-2:0], 1'b0};
    assign two_u_m = two_u - m_ext;
    assign new_u   = two_u_m[ACC_W-1] ? two_u : two_u_m;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
            cnt <= '0;
            fin <= 1'b0;
        end else begin
            fin <= step & last;
            if (step) begin
                run <= ~last;
                cnt <= cnt_cur + 1'b1; // wraps to 0 after the last bit
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            s <= new_s;
            u <= new_u;
        end
    end

    assign p = s[DATA_W-1:0]; // stays put once run drops

endmodule

`default_nettype wire

// File: hdl/modarith_execute.sv
`timescale 1ns/1ps
`default_nettype none

module modarith_execute import modarith_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  mod_cmd_t          exe_cmd,
    input  logic              add_go,
    input  logic              mul_go,
    output logic [DATA_W-1:0] exe_value,
    output logic              exe_done
);

    logic [DATA_W-1:0] addsub_val;
    logic [DATA_W-1:0] addsub_r;
    logic              add_done_r;
    logic [DATA_W-1:0] prod;
    logic              fin;

    // add, then take m off once if the sum reached it
    function automatic logic [DATA_W-1:0] add_mod(input logic [DATA_W-1:0] x,
                                                  input logic [DATA_W-1:0] y,
                                                  input logic [DATA_W-1:0] md);
        logic [DATA_W:0] raw;
        logic [DATA_W:0] red;
        raw = {1'b0, x} + {1'b0, y};
        red = raw - {1'b0, md};
        return red[DATA_W] ? raw[DATA_W-1:0] : red[DATA_W-1:0];
    endfunction

    // subtract, then put m back if it went negative
    function automatic logic [DATA_W-1:0] sub_mod(input logic [DATA_W-1:0] x,
                                                  input logic [DATA_W-1:0] y,
                                                  input logic [DATA_W-1:0] md);
        logic [DATA_W:0] raw;
        logic [DATA_W:0] fix;
        raw = {1'b0, x} - {1'b0, y};
        fix = raw + {1'b0, md};
        return raw[DATA_W] ? fix[DATA_W-1:0] : raw[DATA_W-1:0];
    endfunction

    assign addsub_val = (exe_cmd.op == OP_SUB) ? sub_mod(exe_cmd.a, exe_cmd.b, exe_cmd.m)
                                               : add_mod(exe_cmd.a, exe_cmd.b, exe_cmd.m);

    always_ff @(posedge clk) begin
        if (add_go) begin
            addsub_r <= addsub_val;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            add_done_r <= 1'b0;
        end else begin
            add_done_r <= add_go;
        end
    end

    modmul_serial u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .go    (mul_go),
        .a     (exe_cmd.a),
        .b     (exe_cmd.b),
        .m     (exe_cmd.m),
        .p     (prod),
        .fin   (fin)
    );

    // product already sits in the multiplier's accumulator
    assign exe_value = fin ? prod : addsub_r;
    assign exe_done  = add_done_r | fin;

endmodule

`default_nettype wire

// File: hdl/modarith_result.sv
`timescale 1ns/1ps
`default_nettype none

module modarith_result import modarith_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              exe_done,
    input  logic              bad_op,
    input  logic [DATA_W-1:0] exe_value,
    output mod_res_t          res,
    output logic              done
);

    // decode never raises bad_op and a go together, so the two never collide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res  <= '0;
            done <= 1'b0;
        end else begin
            done <= exe_done | bad_op;
            if (exe_done) begin
                res <= '{value: exe_value, err: 1'b0};
            end else if (bad_op) begin
                res <= '{value: '0, err: 1'b1}; // illegal opcode
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/modarith_top.sv
`timescale 1ns/1ps
`default_nettype none

module modarith_top import modarith_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  mod_cmd_t cmd,
    output logic     busy,
    output logic     done,
    output mod_res_t res
);

    mod_cmd_t          exe_cmd;
    logic              add_go;
    logic              mul_go;
    logic              bad_op;
    logic              exe_done;
    logic [DATA_W-1:0] exe_value;

    modarith_decode u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .cmd     (cmd),
        .done    (done),     // releases busy
        .exe_cmd (exe_cmd),
        .add_go  (add_go),
        .mul_go  (mul_go),
        .bad_op  (bad_op),
        .busy    (busy)
    );

    modarith_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .exe_cmd   (exe_cmd),
        .add_go    (add_go),
        .mul_go    (mul_go),
        .exe_value (exe_value),
        .exe_done  (exe_done)
    );

    modarith_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .exe_done  (exe_done),
        .bad_op    (bad_op),
        .exe_value (exe_value),
        .res       (res),
        .done      (done)
    );

endmodule

`default_nettype wire

// File: tests/modarith_properties.sv
`timescale 1ns/1ps
`default_nettype none

module modarith_properties import modarith_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic done
);

    logic seen_start; // a start was presented since reset
    int   failures = 0; // failed assertions so far

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_start <= 1'b0;
        end else if (start) begin
            seen_start <= 1'b1;
        end
    end

    done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            failures++;
            $error("done stayed high for two cycles");
        end

    done_in_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
        else begin
            failures++;
            $error("done high while busy is low");
        end

    busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
                                       $rose(busy) |-> $past(start))
        else begin
            failures++;
            $error("busy rose without a start");
        end

    quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
                                        !seen_start |-> !done)
        else begin
            failures++;
            $error("done pulsed before any start");
        end

endmodule

bind modarith_top modarith_properties u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .busy  (busy),
    .done  (done)
);

`default_nettype wire

// File: tests/modarith_tb.sv
`timescale 1ns/1ps
`default_nettype none

module modarith_tb import modarith_pkg::*; ();

    localparam int SEED      = 85979;
    localparam int N_ADDSUB  = 16;
    localparam int N_MUL     = 5;
    localparam int N_EDGE    = 7;
    localparam int N_ILLEGAL = 2;
    localparam int N_BUSY    = 2; // accepted command plus the ignored start
    localparam int N_CMDS    = N_ADDSUB + N_MUL + N_EDGE + N_ILLEGAL + N_BUSY;
    localparam int TIMEOUT   = 300 * N_CMDS + 50;

    logic     clk;
    logic     rst_n;
    logic     start;
    mod_cmd_t cmd;
    logic     busy;
    logic     done;
    mod_res_t res;

    int cycle;
    int checks;
    int mismatches;
    int other_errors;

    // one entry per accepted command in issue order
    mod_res_t exp_q[$];
    string    name_q[$];
    int       lat_q[$];
    int       t0_q[$];

    modarith_top u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .cmd   (cmd),
        .busy  (busy),
        .done  (done),
        .res   (res)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : watchdog
        while (cycle < TIMEOUT) begin
            @(posedge clk);
            cycle = cycle + 1;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("Simulation FAILED");
        $finish;
    end

    // expected result straight from modular arithmetic on 512-bit integers
    function automatic mod_res_t ref_modop(input mod_op_e op, input logic [DATA_W-1:0] a,
                                           input logic [DATA_W-1:0] b,
                                           input logic [DATA_W-1:0] m);
        logic [2*DATA_W-1:0] wa;
        logic [2*DATA_W-1:0] wb;
        logic [2*DATA_W-1:0] wm;
        logic [2*DATA_W-1:0] wide;
        mod_res_t            r;
        wa = {{DATA_W{1'b0}}, a};
        wb = {{DATA_W{1'b0}}, b};
        wm = {{DATA_W{1'b0}}, m};
        case (op)
            OP_ADD:  wide = (wa + wb) % wm;
            OP_SUB:  wide = (wa + wm - wb) % wm;
            OP_MUL:  wide = (wa * wb) % wm;
            default: wide = '0;
        endcase
        r.value = wide[DATA_W-1:0];
        r.err   = (op != OP_ADD) && (op != OP_SUB) && (op != OP_MUL);
        return r;
    endfunction

    // edges from the start edge to the done cycle
    function automatic int expected_latency(input mod_op_e op);
        case (op)
            OP_ADD, OP_SUB: return 3;
            OP_MUL:         return DATA_W + 2;
            default:        return 2;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] rand_word();
        logic [DATA_W-1:0] r;
        r = '0;
        for (int i = 0; i < DATA_W / 32; i++) begin
            r = {r[DATA_W-33:0], $urandom()};
        end
        return r;
    endfunction

    // odd modulus of random size and always above 1
    function automatic logic [DATA_W-1:0] rand_modulus();
        logic [DATA_W-1:0] r;
        r = (rand_word() >> ($urandom() % 200)) | 1;
        return (r == 1) ? 3 : r;
    endfunction

    function automatic logic [DATA_W-1:0] rand_below(input logic [DATA_W-1:0] m);
        return rand_word() % m;
    endfunction

    function automatic mod_cmd_t make_cmd(input mod_op_e op, input logic [DATA_W-1:0] a,
                                          input logic [DATA_W-1:0] b,
                                          input logic [DATA_W-1:0] m);
        mod_cmd_t c;
        c.op = op;
        c.a  = a;
        c.b  = b;
        c.m  = m;
        return c;
    endfunction

    // runs from a falling edge to the falling edge after the start edge
    task automatic issue_cmd(input string name, input mod_cmd_t c);
        while (busy) begin
            @(negedge clk);
        end
        exp_q.push_back(ref_modop(c.op, c.a, c.b, c.m));
        name_q.push_back(name);
        lat_q.push_back(expected_latency(c.op));
        t0_q.push_back(cycle + 1); // number of the coming start edge
        cmd   = c;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    initial begin : compare
        mod_res_t exp_res;
        string    name;
        int       lat;
        int       t0;
        forever begin
            @(negedge clk);
            if (done === 1'b1) begin
                assert (exp_q.size() != 0) else begin
                    other_errors++;
                    $display("error: done pulsed at cycle %0d with no command pending", cycle);
                end
                if (exp_q.size() != 0) begin
                    exp_res = exp_q.pop_front();
                    name    = name_q.pop_front();
                    lat     = lat_q.pop_front();
                    t0      = t0_q.pop_front();
                    checks++;
                    assert (res === exp_res) else begin
                        mismatches++;
                        $display("mismatch: %s expected %h actual %h", name, exp_res, res);
                    end
                    assert (cycle - t0 == lat) else begin
                        mismatches++;
                        $display("mismatch: %s latency expected %0d actual %0d",
                                 name, lat, cycle - t0);
                    end
                end
            end
        end
    end

    initial begin : stimulus
        logic [DATA_W-1:0] m;
        mod_op_e           op;
        mod_res_t          held_res;
        mod_res_t          zero_res;
        void'($urandom(SEED));
        rst_n    = 1'b0;
        start    = 1'b0;
        cmd      = '0;
        zero_res = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle after reset
        repeat (4) begin
            @(negedge clk);
            assert (done === 1'b0 && busy === 1'b0) else begin
                other_errors++;
                $display("error: done or busy went high before any start");
            end
            assert (res === zero_res) else begin
                mismatches++;
                $display("mismatch: reset expected %h actual %h", zero_res, res);
            end
        end

        for (int i = 0; i < N_ADDSUB; i++) begin
            m  = rand_modulus();
            op = ($urandom() % 2 == 0) ? OP_ADD : OP_SUB;
            issue_cmd($sformatf("addsub_%0d", i),
                      make_cmd(op, rand_below(m), rand_below(m), m));
        end

        m = rand_modulus();
        issue_cmd("add_zero_top", make_cmd(OP_ADD, 0, m - 1, m));
        issue_cmd("add_top_top", make_cmd(OP_ADD, m - 1, m - 1, m));
        issue_cmd("sub_zero_top", make_cmd(OP_SUB, 0, m - 1, m));
        issue_cmd("sub_top_zero", make_cmd(OP_SUB, m - 1, 0, m));
        issue_cmd("mul_one", make_cmd(OP_MUL, 1, rand_below(m), m));
        issue_cmd("mul_zero", make_cmd(OP_MUL, rand_below(m), 0, m));
        issue_cmd("mul_top_top", make_cmd(OP_MUL, m - 1, m - 1, m));

        for (int i = 0; i < N_MUL; i++) begin
            m = rand_modulus();
            issue_cmd($sformatf("mul_%0d", i),
                      make_cmd(OP_MUL, rand_below(m), rand_below(m), m));
        end

        for (int i = 0; i < N_ILLEGAL; i++) begin
            m = rand_modulus();
            issue_cmd($sformatf("illegal_%0d", i),
                      make_cmd(mod_op_e'(2'b11), rand_below(m), rand_below(m), m));
        end

        // second start lands mid-multiply and must be dropped
        m = rand_modulus();
        issue_cmd("busy_first", make_cmd(OP_MUL, rand_below(m), rand_below(m), m));
        held_res = exp_q[exp_q.size() - 1];
        assert (busy === 1'b1) else begin
            other_errors++;
            $display("error: busy not raised after an accepted start");
        end
        cmd   = make_cmd(OP_ADD, m - 1, m - 1, m);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (10) begin
            @(negedge clk);
            assert (res === held_res) else begin
                mismatches++;
                $display("mismatch: busy_hold expected %h actual %h", held_res, res);
            end
        end

        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 checks, mismatches, other_errors, u_dut.u_props.failures);
        if (mismatches == 0 && other_errors == 0 && u_dut.u_props.failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hdl/modarith_pkg.sv
hdl/modarith_decode.sv
hdl/modmul_serial.sv
hdl/modarith_execute.sv
hdl/modarith_result.sv
hdl/modarith_top.sv
tests/modarith_properties.sv
tests/modarith_tb.sv

// File: run_sim.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module modarith_tb -f build.f -o modarith_sim

./obj_dir/modarith_sim | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0
